//--- include/vc_link_config.svh
// --------------------------------------------------
// Build-time sizes of the VC credit link.
// VC count, payload width, credit limits and derived widths.
// --------------------------------------------------
`ifndef VC_LINK_CONFIG_SVH
`define VC_LINK_CONFIG_SVH

// Virtual channels sharing the link.
`define VC_NUM_VCS 4
// Payload bits per flit.
`define VC_DATA_WIDTH 16
// Most credits one VC can hold.
`define VC_MAX_CREDIT 7
// Most credits one VC gets back per cycle.
`define VC_CREDIT_CHANGE_MAX 2

// Derived widths.
`define VC_ID_WIDTH ($clog2(`VC_NUM_VCS))
`define VC_COUNT_WIDTH ($clog2(`VC_MAX_CREDIT + 1))
`define VC_CHANGE_WIDTH ($clog2(`VC_CREDIT_CHANGE_MAX + 1))

`endif

//--- rtl/vc_link_pkg.sv
// --------------------------------------------------
// Shared types of the VC credit link.
// Link flit, receiver credit return word, credit status.
// --------------------------------------------------
`include "vc_link_config.svh"

package vc_link_pkg;

  // One flit on the shared link.
  typedef struct packed {
    // Virtual channel the payload belongs to.
    logic [`VC_ID_WIDTH-1:0]   vc;
    logic [`VC_DATA_WIDTH-1:0] data;
  } vc_flit_t;

  // Word the receiver drives back every cycle.
  typedef struct packed {
    // Receiver is in reset, all counters reload.
    logic                                          receiver_in_reset;
    // Credits returned this cycle, one field per VC.
    logic [`VC_NUM_VCS-1:0][`VC_CHANGE_WIDTH-1:0] count;
  } vc_credit_return_t;

  // Credit state of one VC.
  typedef struct packed {
    // Stored credits.
    logic [`VC_COUNT_WIDTH-1:0] count;
    // Credits usable now, after withhold.
    logic [`VC_COUNT_WIDTH-1:0] available;
  } vc_credit_status_t;

endpackage

//--- rtl/vc_credit_return_stage.sv
// --------------------------------------------------
// Receiver credit return register.
// Per-VC increments and the counter reload level.
// --------------------------------------------------
`timescale 1ns/1ns
`include "vc_link_config.svh"

module vc_credit_return_stage (
  input  logic                                          clk,
  input  logic                                          arst_n,
  // Raw return word from the receiver.
  input  vc_link_pkg::vc_credit_return_t                credit_return,
  // Credits to add, one field per VC.
  output logic [`VC_NUM_VCS-1:0][`VC_CHANGE_WIDTH-1:0] incr,
  // Reload all counters from their initial value.
  output logic                                          reload
);

  // Registered copy of the receiver word.
  vc_link_pkg::vc_credit_return_t return_q;

  // --------------------------------------------------
  // Input register
  // --------------------------------------------------
  // One cycle of delay on the whole word.
  // Counters add it at the following edge.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      return_q <= '0;
    end else begin
      return_q <= credit_return;
    end
  end

  // Receiver reset becomes a reload level one cycle later.
  assign reload = return_q.receiver_in_reset;

  // Credits sent alongside a receiver reset are dropped.
  // The reload restores the full count anyway.
  assign incr = reload ? '0 : return_q.count;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // The receiver returns at most the agreed amount per VC.
  for (genvar i = 0; i < `VC_NUM_VCS; i++) begin : gen_chk
    a_return_in_range: assert property (
      @(posedge clk) disable iff (!arst_n)
      credit_return.count[i] <= `VC_CREDIT_CHANGE_MAX
    );
  end

endmodule

//--- rtl/vc_credit_counter.sv
// --------------------------------------------------
// Credit counter of one virtual channel.
// Initial load, return increment, send decrement, withhold.
// --------------------------------------------------
`timescale 1ns/1ns
`include "vc_link_config.svh"

module vc_credit_counter #(
  // Largest count this VC may ever hold.
  parameter int max_credit = `VC_MAX_CREDIT
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // Receiver reset reload level.
  input  logic                           reload,
  // Count loaded at reset and on reload.
  input  logic [`VC_COUNT_WIDTH-1:0]     initial_value,
  // Credits returned this cycle.
  input  logic [`VC_CHANGE_WIDTH-1:0]    incr,
  // One flit sent this cycle.
  input  logic                           decr,
  // Credits held back from use.
  input  logic [`VC_COUNT_WIDTH-1:0]     withhold,
  output vc_link_pkg::vc_credit_status_t status
);

  localparam int cw = `VC_COUNT_WIDTH;

  // Set by the async reset, held one cycle after it.
  logic          load_q;
  // Any reason to reload this cycle.
  logic          load;
  // Stored credit count.
  logic [cw-1:0] count_q;
  // Count after this cycle's changes, one spare bit.
  logic [cw:0]   count_next;

  // --------------------------------------------------
  // Load control
  // --------------------------------------------------
  // Every edge while arst_n is low loads initial_value.
  // The first edge after release loads it once more.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_q <= 1'b1;
    end else begin
      load_q <= 1'b0;
    end
  end

  assign load = load_q || reload;

  // --------------------------------------------------
  // Count update
  // --------------------------------------------------
  // Return and send may hit in the same cycle.
  assign count_next = {1'b0, count_q} + (cw + 1)'(incr) - (cw + 1)'(decr);

  always_ff @(posedge clk) begin
    if (load) begin
      count_q <= initial_value;
    end else begin
      count_q <= count_next[cw-1:0];
    end
  end

  // --------------------------------------------------
  // Status
  // --------------------------------------------------
  assign status.count = count_q;

  // Withhold shrinks the usable credit, floored at zero.
  // Nothing is usable while the count is being reloaded.
  always_comb begin
    if (load) begin
      status.available = '0;
    end else if (count_q > withhold) begin
      status.available = count_q - withhold;
    end else begin
      status.available = '0;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Returns never push the count past its limit.
  a_count_max: assert property (
    @(posedge clk) disable iff (!arst_n)
    !load |-> count_next <= (cw + 1)'(max_credit)
  );

  // The arbiter only sends on a VC that has usable credit.
  a_decr_credited: assert property (
    @(posedge clk) disable iff (!arst_n)
    decr |-> status.available != '0
  );

endmodule

//--- rtl/vc_link_arbiter.sv
// --------------------------------------------------
// Round-robin arbiter for the shared link.
// Credited request, grant, payload mux, link register.
// --------------------------------------------------
`timescale 1ns/1ns
`include "vc_link_config.svh"

module vc_link_arbiter (
  input  logic                                        clk,
  input  logic                                        arst_n,
  // Push side, one valid/ready pair per VC.
  input  logic [`VC_NUM_VCS-1:0]                      push_valid,
  input  logic [`VC_NUM_VCS-1:0][`VC_DATA_WIDTH-1:0]  push_data,
  // Credit state from the counters.
  input  vc_link_pkg::vc_credit_status_t [`VC_NUM_VCS-1:0] status,
  output logic [`VC_NUM_VCS-1:0]                      push_ready,
  // Send pulse back to the counters.
  output logic [`VC_NUM_VCS-1:0]                      decr,
  // Link strobe and flit, no back-pressure.
  output logic                                        link_valid,
  output vc_link_pkg::vc_flit_t                       link_flit,
  output logic                                        sender_in_reset
);

  localparam int n  = `VC_NUM_VCS;
  localparam int iw = `VC_ID_WIDTH;

  // VCs that are valid and hold usable credit.
  logic [n-1:0]  request;
  // One-hot winner of this cycle.
  logic [n-1:0]  grant;
  // Someone won this cycle.
  logic          granted;
  // Number of the winner.
  logic [iw-1:0] win_id;
  // Last winner, the search starts just after it.
  logic [iw-1:0] last_q;

  // --------------------------------------------------
  // Request and grant
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < n; i++) begin
      request[i] = push_valid[i] && (status[i].available != '0);
    end
  end

  // Walk once around the ring from last_q + 1.
  // The first requester found wins.
  always_comb begin
    int idx;
    idx     = 0;
    grant   = '0;
    win_id  = '0;
    granted = 1'b0;
    for (int k = 1; k <= n; k++) begin
      idx = (int'(last_q) + k) % n;
      if (!granted && request[idx]) begin
        grant[idx] = 1'b1;
        win_id     = iw'(idx);
        granted    = 1'b1;
      end
    end
  end

  // Ready goes only to the winner.
  assign push_ready = grant;

  // Counters drop a credit for each taken push.
  assign decr = push_ready & push_valid;

  // --------------------------------------------------
  // Pointer, strobe and reset flag
  // --------------------------------------------------
  // VC 0 has first pick after reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_q          <= iw'(n - 1);
      link_valid      <= 1'b0;
      sender_in_reset <= 1'b1;
    end else begin
      sender_in_reset <= 1'b0;
      link_valid      <= granted;
      // Pointer stays put on idle cycles.
      if (granted) begin
        last_q <= win_id;
      end
    end
  end

  // --------------------------------------------------
  // Link payload
  // --------------------------------------------------
  // Flit leaves one cycle after its push is taken.
  always_ff @(posedge clk) begin
    if (granted) begin
      link_flit.vc   <= win_id;
      link_flit.data <= push_data[win_id];
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // At most one VC is taken per cycle.
  a_ready_onehot0: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(push_ready)
  );

endmodule

//--- rtl/vc_credit_sender.sv
// --------------------------------------------------
// Credit sender for VCs sharing one link.
// Return stage, per-VC counters and link arbiter.
// --------------------------------------------------
`timescale 1ns/1ns
`include "vc_link_config.svh"

module vc_credit_sender (
  input  logic                                              clk,
  input  logic                                              arst_n,
  // Push side, one valid/ready pair per VC.
  input  logic [`VC_NUM_VCS-1:0]                            push_valid,
  input  logic [`VC_NUM_VCS-1:0][`VC_DATA_WIDTH-1:0]        push_data,
  output logic [`VC_NUM_VCS-1:0]                            push_ready,
  // Credit setup per VC.
  input  logic [`VC_NUM_VCS-1:0][`VC_COUNT_WIDTH-1:0]       credit_initial,
  input  logic [`VC_NUM_VCS-1:0][`VC_COUNT_WIDTH-1:0]       credit_withhold,
  // Return word from the receiver.
  input  vc_link_pkg::vc_credit_return_t                    credit_return,
  // Shared link.
  output logic                                              link_valid,
  output vc_link_pkg::vc_flit_t                             link_flit,
  output logic                                              sender_in_reset,
  // Credit state per VC.
  output vc_link_pkg::vc_credit_status_t [`VC_NUM_VCS-1:0]  status
);

  // Credits to add per VC.
  logic [`VC_NUM_VCS-1:0][`VC_CHANGE_WIDTH-1:0] incr;
  // Receiver reset, delayed.
  logic                                         reload;
  // Credits spent per VC.
  logic [`VC_NUM_VCS-1:0]                       decr;

  // --------------------------------------------------
  // Credit return
  // --------------------------------------------------
  vc_credit_return_stage u_return_stage (
    .clk           (clk),
    .arst_n        (arst_n),
    .credit_return (credit_return),
    .incr          (incr),
    .reload        (reload)
  );

  // --------------------------------------------------
  // Counters, one per VC
  // --------------------------------------------------
  for (genvar i = 0; i < `VC_NUM_VCS; i++) begin : gen_vc
    vc_credit_counter #(
      .max_credit (`VC_MAX_CREDIT)
    ) u_counter (
      .clk           (clk),
      .arst_n        (arst_n),
      .reload        (reload),
      .initial_value (credit_initial[i]),
      .incr          (incr[i]),
      .decr          (decr[i]),
      .withhold      (credit_withhold[i]),
      .status        (status[i])
    );
  end

  // --------------------------------------------------
  // Arbiter and link
  // --------------------------------------------------
  vc_link_arbiter u_arbiter (
    .clk             (clk),
    .arst_n          (arst_n),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .status          (status),
    .push_ready      (push_ready),
    .decr            (decr),
    .link_valid      (link_valid),
    .link_flit       (link_flit),
    .sender_in_reset (sender_in_reset)
  );

endmodule

//--- test/tb_vc_credit_sender.sv
// --------------------------------------------------
// Testbench of the VC credit sender.
// Clock, reset, seeded random pushes and receiver returns,
// reference credit model and concurrent checks.
// --------------------------------------------------
`timescale 1ns/1ns
`include "vc_link_config.svh"

module tb_vc_credit_sender;

  localparam int n   = `VC_NUM_VCS;
  localparam int cw  = `VC_COUNT_WIDTH;
  localparam int dw  = `VC_DATA_WIDTH;
  localparam int iw  = `VC_ID_WIDTH;
  localparam int chw = `VC_CHANGE_WIDTH;
  localparam int clk_period     = 40;
  localparam int reset_cycles   = 10;
  localparam int traffic_cycles = 3000;
  // Returns trickle back at up to 2 per cycle, so a drain is short.
  localparam int drain_budget   = 990;
  localparam int timeout_cycles = reset_cycles + traffic_cycles + drain_budget;

  logic                                   clk;
  logic                                   arst_n;
  logic [n-1:0]                           push_valid;
  logic [n-1:0][dw-1:0]                   push_data;
  logic [n-1:0]                           push_ready;
  logic [n-1:0][cw-1:0]                   credit_initial;
  logic [n-1:0][cw-1:0]                   credit_withhold;
  vc_link_pkg::vc_credit_return_t         credit_return;
  logic                                   link_valid;
  vc_link_pkg::vc_flit_t                  link_flit;
  logic                                   sender_in_reset;
  vc_link_pkg::vc_credit_status_t [n-1:0] status;

  // Reference model state, updated at each rising edge.
  int                             exp_count [n];
  int                             exp_avail [n];
  logic [n-1:0]                   exp_request;
  logic                           exp_load;
  logic                           exp_sir;
  logic                           exp_pending;
  vc_link_pkg::vc_flit_t          exp_flit;
  vc_link_pkg::vc_flit_t          flit_queue [$];
  // Receiver word of the cycle that just ended.
  vc_link_pkg::vc_credit_return_t return_seen;
  logic                           first_after_reset;
  // Pushes taken in the cycle that just ended.
  logic [n-1:0]                   taken;
  // Grants to other VCs while a VC kept requesting.
  int                             wait_grants [n];
  // Receiver side, credits it still owes per VC.
  int                             owed [n];
  int                             sent_per_vc [n];
  int                             sent_after_rx_reset;
  int                             cycle_count;

  vc_credit_sender DUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .push_ready      (push_ready),
    .credit_initial  (credit_initial),
    .credit_withhold (credit_withhold),
    .credit_return   (credit_return),
    .link_valid      (link_valid),
    .link_flit       (link_flit),
    .sender_in_reset (sender_in_reset),
    .status          (status)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic report_mismatch(input string what);
    $display("mismatch at %0t ns: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "check stopped the run");
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Usable credit and request per VC in the current cycle.
  always_comb begin
    for (int i = 0; i < n; i++) begin
      if (exp_load) begin
        exp_avail[i] = 0;
      end else if (exp_count[i] > int'(credit_withhold[i])) begin
        exp_avail[i] = exp_count[i] - int'(credit_withhold[i]);
      end else begin
        exp_avail[i] = 0;
      end
      exp_request[i] = push_valid[i] && (exp_avail[i] > 0);
    end
  end

  // Reads the values of the cycle that just ended.
  always @(posedge clk) begin : model_update
    logic [n-1:0]          granted;
    vc_link_pkg::vc_flit_t flit;
    granted = push_ready & push_valid;
    taken   = granted;
    // Fairness bookkeeping.
    for (int i = 0; i < n; i++) begin
      if (granted[i] || !exp_request[i]) begin
        wait_grants[i] = 0;
      end else if (granted != '0) begin
        wait_grants[i] = wait_grants[i] + 1;
      end
    end
    // The flit on the link was matched at the negative edge.
    if (link_valid && flit_queue.size() != 0) begin
      void'(flit_queue.pop_front());
    end
    // Receiver drops flits and debts while it is in reset.
    if (credit_return.receiver_in_reset) begin
      sent_after_rx_reset = 0;
      for (int i = 0; i < n; i++) begin
        owed[i] = 0;
      end
    end else begin
      for (int i = 0; i < n; i++) begin
        owed[i] = owed[i] - int'(credit_return.count[i]);
      end
      if (link_valid) begin
        owed[link_flit.vc]        = owed[link_flit.vc] + 1;
        sent_per_vc[link_flit.vc] = sent_per_vc[link_flit.vc] + 1;
        sent_after_rx_reset       = sent_after_rx_reset + 1;
      end
    end
    for (int i = 0; i < n; i++) begin
      if (granted[i]) begin
        flit.vc   = iw'(i);
        flit.data = push_data[i];
        flit_queue.push_back(flit);
      end
    end
    // Counts: load, or add the return seen one cycle back minus sends.
    if (!arst_n) begin
      first_after_reset = 1'b1;
      return_seen       = '0;
      flit_queue.delete();
      for (int i = 0; i < n; i++) begin
        exp_count[i] = int'(credit_initial[i]);
        owed[i]      = 0;
      end
    end else begin
      for (int i = 0; i < n; i++) begin
        if (first_after_reset || return_seen.receiver_in_reset) begin
          exp_count[i] = int'(credit_initial[i]);
        end else begin
          exp_count[i] = exp_count[i] + int'(return_seen.count[i]) - int'(taken[i]);
        end
      end
      first_after_reset = 1'b0;
      return_seen       = credit_return;
    end
    exp_load    = first_after_reset || return_seen.receiver_in_reset;
    exp_sir     = !arst_n;
    exp_pending = flit_queue.size() != 0;
    exp_flit    = exp_pending ? flit_queue[0] : '0;
  end

  // --------------------------------------------------
  // Checks, sampled mid-cycle
  // --------------------------------------------------
  a_reset_flag: assert property (@(negedge clk) sender_in_reset == exp_sir)
    else report_mismatch("sender_in_reset");
  a_reset_quiet: assert property (@(negedge clk) !arst_n |-> !link_valid && push_ready == '0)
    else report_mismatch("link or ready active during reset");
  a_link_strobe: assert property (@(negedge clk) disable iff (!arst_n)
    link_valid == exp_pending)
    else report_mismatch("link_valid against taken pushes");
  a_link_flit: assert property (@(negedge clk) disable iff (!arst_n)
    link_valid |-> link_flit == exp_flit)
    else report_mismatch("link_flit vc or data");
  a_one_ready: assert property (@(negedge clk) disable iff (!arst_n) $onehot0(push_ready))
    else report_mismatch("more than one push_ready");
  a_load_quiet: assert property (@(negedge clk) disable iff (!arst_n)
    exp_load |-> push_ready == '0)
    else report_mismatch("push_ready during reload");
  a_work_conserving: assert property (@(negedge clk) disable iff (!arst_n)
    exp_request != '0 |-> push_ready != '0)
    else report_mismatch("credited request left without grant");

  for (genvar i = 0; i < n; i++) begin : gen_vc_check
    a_count: assert property (@(negedge clk) disable iff (!arst_n)
      int'(status[i].count) == exp_count[i])
      else report_mismatch($sformatf("VC %0d count %0d, model %0d",
                                     i, status[i].count, exp_count[i]));
    a_available: assert property (@(negedge clk) disable iff (!arst_n)
      int'(status[i].available) == exp_avail[i])
      else report_mismatch($sformatf("VC %0d available %0d, model %0d",
                                     i, status[i].available, exp_avail[i]));
    a_ready_credited: assert property (@(negedge clk) disable iff (!arst_n)
      push_ready[i] |-> exp_request[i])
      else report_mismatch($sformatf("VC %0d ready without valid and credit", i));
    a_fair: assert property (@(negedge clk) disable iff (!arst_n) wait_grants[i] < n)
      else report_mismatch($sformatf("VC %0d passed over too often", i));
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  // Taken pushes drop, idle VCs raise a new flit at random.
  task automatic drive_pushes(input int valid_pct);
    for (int i = 0; i < n; i++) begin
      if (taken[i]) begin
        push_valid[i] = 1'b0;
      end
      if (!push_valid[i] && int'($urandom_range(99, 0)) < valid_pct) begin
        push_valid[i] = 1'b1;
        push_data[i]  = dw'($urandom);
      end
    end
  endtask

  // Receiver returns part of its debt, with a random delay.
  task automatic drive_returns(input logic in_reset);
    int limit;
    int amount;
    credit_return.receiver_in_reset = in_reset;
    for (int i = 0; i < n; i++) begin
      amount = 0;
      if (!in_reset && owed[i] > 0 && $urandom_range(3, 0) != 0) begin
        limit  = (owed[i] < `VC_CREDIT_CHANGE_MAX) ? owed[i] : `VC_CREDIT_CHANGE_MAX;
        amount = $urandom_range(limit, 1);
      end
      credit_return.count[i] = chw'(amount);
    end
  endtask

  task automatic drive_withhold();
    for (int i = 0; i < n; i++) begin
      credit_withhold[i] = cw'($urandom_range(3, 0));
    end
  endtask

  // No push pending and every credit back home.
  function automatic bit credits_home();
    if (push_valid != '0) begin
      return 1'b0;
    end
    for (int i = 0; i < n; i++) begin
      if (exp_count[i] != int'(credit_initial[i])) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic bit every_vc_sent();
    for (int i = 0; i < n; i++) begin
      if (sent_per_vc[i] == 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  always @(posedge clk) begin : timeout_watch
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      report_failure("timeout, the credits did not drain in time");
    end
  end

  initial begin : main
    logic rx_reset;
    int   valid_pct;
    void'($urandom(32'h2428_4c33));
    clk             = 1'b0;
    arst_n          = 1'b1;
    push_valid      = '0;
    push_data       = '0;
    credit_withhold = '0;
    credit_return   = '0;
    cycle_count     = 0;
    for (int i = 0; i < n; i++) begin
      credit_initial[i] = cw'($urandom_range(`VC_MAX_CREDIT, 2));
    end
    #2 arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #5 arst_n = 1'b1;
    // Light traffic, saturation with a receiver reset, mixed traffic.
    for (int t = 0; t < traffic_cycles; t++) begin
      @(posedge clk);
      #5;
      valid_pct = (t < 1000) ? 40 : ((t < 2000) ? 100 : 70);
      drive_pushes(valid_pct);
      if (t >= 1000 && t < 2000) begin
        credit_withhold = '0;
      end else if (t % 64 == 0) begin
        drive_withhold();
      end
      rx_reset = (t >= 1500 && t < 1503) || (t >= 2500 && t < 2503);
      drive_returns(rx_reset);
    end
    // Drain.
    credit_withhold = '0;
    while (!credits_home()) begin
      @(posedge clk);
      #5;
      drive_pushes(0);
      drive_returns(1'b0);
    end
    repeat (4) @(posedge clk);
    if (sent_after_rx_reset > 0 && every_vc_sent()) begin
      $display("Regression passed");
      $finish;
    end else begin
      report_failure("no traffic after the receiver reset, or a VC never sent");
    end
  end

endmodule

//--- build.f
+incdir+include
rtl/vc_link_pkg.sv
rtl/vc_credit_return_stage.sv
rtl/vc_credit_counter.sv
rtl/vc_link_arbiter.sv
rtl/vc_credit_sender.sv
test/tb_vc_credit_sender.sv

//--- Makefile
# Verilator regression for the VC credit sender.
TOP := tb_vc_credit_sender

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
